/* common/dataPortIf.sv */
`timescale 1ns/10ps

interface dataPortIf
    import tinkerPkg::*;
();

    logic read;      // Load or return, one cycle
    logic write;     // Store or call, lands on the clock edge
    wordT address;   // Byte address of the 8-byte word
    wordT writeData; // Little-endian store data
    wordT readData;  // Combinational, follows address

    modport exec (output read, write, address, writeData, input readData);
    modport mem (input read, write, address, writeData, output readData);

endinterface

/* common/decodeIf.sv */
`timescale 1ns/10ps

interface decodeIf
    import tinkerPkg::*;
();

    opcodeT   opcode;  // Latched opcode
    regIndexT rd;      // Destination, also store base and jump target
    regIndexT rs;      // Source, already remapped to rd for immediates
    regIndexT rt;      // Second source
    literalT  literal; // Raw 12-bit literal

    modport ctrl (output opcode, rd, rs, rt, literal);
    modport exec (input opcode, rd, rs, rt, literal);
    modport regs (input rd, rs, rt);

endinterface

/* common/tinkerPkg.sv */
package tinkerPkg;

    // ------------------------------------------------------------------------
    // Widths with a meaning
    // ------------------------------------------------------------------------
    typedef logic [63:0] wordT;     // Register value, address or data word
    typedef logic [31:0] instrT;    // One instruction
    typedef logic [4:0]  regIndexT; // Register number
    typedef logic [11:0] literalT;  // Literal field, zero-extended on use

    // Kept opcodes only, others decode as no-ops
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHR    = 5'h04,
        OP_SHRI   = 5'h05,
        OP_SHL    = 5'h06,
        OP_SHLI   = 5'h07,
        OP_JMPR   = 5'h08,
        OP_JMPA   = 5'h09,
        OP_JMPAI  = 5'h0A,
        OP_BRNZ   = 5'h0B,
        OP_CALL   = 5'h0C,
        OP_RETURN = 5'h0D,
        OP_BRGT   = 5'h0E,
        OP_HLT    = 5'h0F,
        OP_LOAD   = 5'h10,
        OP_MOV    = 5'h11,
        OP_LI     = 5'h12,
        OP_STORE  = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B,
        OP_MUL    = 5'h1C
    } opcodeT;

    // Instruction phases
    typedef enum logic [2:0] {
        FETCH         = 3'd0,
        DECODE        = 3'd1,
        EXECUTE       = 3'd2,
        MEMORY_ACCESS = 3'd3,
        WRITE_BACK    = 3'd4,
        HALTED        = 3'd5 // Sticky until reset
    } coreStateT;

    // ------------------------------------------------------------------------
    // Constants
    // ------------------------------------------------------------------------
    localparam regIndexT StackReg = 5'd31;         // Stack pointer
    localparam int DefaultMemBytes = 65536;        // Power of two
    localparam wordT DefaultResetPc = 64'h2000;    // First fetch address

endpackage

/* control/coreControl.sv */
`timescale 1ns/10ps

module coreControl
    import tinkerPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  instrT instruction, // From fetch port, valid while PC holds
    decodeIf.ctrl dec,
    output logic  execStrobe,
    output logic  memStrobe,
    output logic  pcStrobe,
    output logic  regWrite,
    output logic  hlt
);

    coreStateT state;
    coreStateT nextState;

    opcodeT   newOpcode; // Fields of the instruction at PC
    regIndexT newRd;

    assign newOpcode = opcodeT'(instruction[31:27]);
    assign newRd     = instruction[26:22];

    // ------------------------------------------------------------------------
    // Field latch, captured at the end of DECODE
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec.opcode  <= OP_AND;
            dec.rd      <= '0;
            dec.rs      <= '0;
            dec.rt      <= '0;
            dec.literal <= '0;
        end else if (state == DECODE) begin
            dec.opcode  <= newOpcode;
            dec.rd      <= newRd;
            dec.rt      <= instruction[16:12];
            dec.literal <= instruction[11:0];
            // Immediate forms read their own destination
            case (newOpcode)
                OP_ADDI, OP_SUBI, OP_SHRI, OP_SHLI, OP_LI: dec.rs <= newRd;
                default: dec.rs <= instruction[21:17];
            endcase
        end
    end

    // State register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    // Next state from the latched opcode
    always_comb begin
        nextState = state;
        case (state)
            FETCH:  nextState = DECODE;
            DECODE: nextState = EXECUTE;
            EXECUTE: begin
                case (dec.opcode)
                    OP_LOAD, OP_STORE, OP_CALL, OP_RETURN: nextState = MEMORY_ACCESS;
                    OP_HLT: nextState = HALTED;
                    OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL,
                    OP_AND, OP_OR, OP_XOR, OP_NOT,
                    OP_SHR, OP_SHRI, OP_SHL, OP_SHLI,
                    OP_MOV, OP_LI: nextState = WRITE_BACK;
                    default: nextState = FETCH; // Jumps, branches, unknown no-ops
                endcase
            end
            MEMORY_ACCESS: nextState = (dec.opcode == OP_LOAD) ? WRITE_BACK : FETCH;
            WRITE_BACK:    nextState = FETCH;
            HALTED:        nextState = HALTED;
            default:       nextState = FETCH;
        endcase
    end

    // ------------------------------------------------------------------------
    // Phase strobes
    // ------------------------------------------------------------------------
    assign execStrobe = (state == EXECUTE);
    assign memStrobe  = (state == MEMORY_ACCESS);
    assign pcStrobe   = (nextState == FETCH); // Last state of the instruction
    assign regWrite   = (state == WRITE_BACK);
    assign hlt        = (state == HALTED);

    // Halt is sticky
    hltSticky : assert property (@(posedge clk) disable iff (reset) hlt |=> hlt);

endmodule

/* execute/executeUnit.sv */
`timescale 1ns/10ps

module executeUnit
    import tinkerPkg::*;
#(
    parameter wordT ResetPc = DefaultResetPc
) (
    input  logic  clk,
    input  logic  reset,
    decodeIf.exec dec,
    input  wordT  rsValue,
    input  wordT  rtValue,
    input  wordT  rdValue,
    input  wordT  stackPtr,   // r31, for call and return
    input  logic  execStrobe,
    input  logic  memStrobe,
    input  logic  pcStrobe,
    dataPortIf.exec mem,
    output wordT  pc,
    output wordT  writeBackData
);

    wordT literalWord; // Zero-extended literal
    wordT operand;     // Second ALU operand
    wordT pcPlus4;
    wordT aluResult;
    wordT dataAddress;
    wordT storeData;
    wordT nextPc;
    logic isRead;
    logic isWrite;

    wordT resultReg;    // Registered at end of EXECUTE
    wordT addressReg;
    wordT storeDataReg;
    wordT nextPcReg;
    logic readPending;  // Memory op waiting for MEMORY_ACCESS
    logic writePending;

    assign literalWord = wordT'(dec.literal);
    assign pcPlus4     = pc + 64'd4;

    // ------------------------------------------------------------------------
    // Operand select and ALU
    // ------------------------------------------------------------------------
    always_comb begin
        case (dec.opcode)
            OP_ADDI, OP_SUBI, OP_SHRI, OP_SHLI, OP_LI,
            OP_LOAD, OP_STORE, OP_JMPAI: operand = literalWord;
            default: operand = rtValue;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            OP_ADD, OP_ADDI:   aluResult = rsValue + operand;
            OP_SUB, OP_SUBI:   aluResult = rsValue - operand;
            OP_MUL:            aluResult = rsValue * operand; // Low 64 bits
            OP_AND:            aluResult = rsValue & operand;
            OP_OR:             aluResult = rsValue | operand;
            OP_XOR:            aluResult = rsValue ^ operand;
            OP_NOT:            aluResult = ~rsValue;
            OP_SHR, OP_SHRI:   aluResult = rsValue >> operand; // Logical
            OP_SHL, OP_SHLI:   aluResult = rsValue << operand;
            OP_MOV:            aluResult = rsValue;
            OP_LI:             aluResult = {rsValue[63:12], operand[11:0]}; // rs is rd here
            default:           aluResult = '0;
        endcase
    end

    // Data address and store data
    always_comb begin
        case (dec.opcode)
            OP_STORE:          dataAddress = rdValue + literalWord;
            OP_CALL, OP_RETURN: dataAddress = stackPtr - 64'd8;
            default:           dataAddress = rsValue + operand; // Load
        endcase
    end

    assign storeData = (dec.opcode == OP_CALL) ? pcPlus4 : rsValue; // Return address on call
    assign isRead    = (dec.opcode == OP_LOAD) || (dec.opcode == OP_RETURN);
    assign isWrite   = (dec.opcode == OP_STORE) || (dec.opcode == OP_CALL);

    // ------------------------------------------------------------------------
    // Next PC
    // ------------------------------------------------------------------------
    always_comb begin
        case (dec.opcode)
            OP_JMPR:  nextPc = rdValue;
            OP_JMPA:  nextPc = pc + rdValue;
            OP_JMPAI: nextPc = pc + literalWord;
            OP_BRNZ:  nextPc = (rsValue != '0) ? rdValue : pcPlus4;
            OP_BRGT:  nextPc = ($signed(rsValue) > $signed(operand)) ? rdValue : pcPlus4;
            OP_CALL:  nextPc = rdValue;
            OP_HLT:   nextPc = pc; // Hold
            default:  nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (execStrobe) begin
            resultReg    <= aluResult;
            addressReg   <= dataAddress;
            storeDataReg <= storeData;
            nextPcReg    <= nextPc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readPending  <= 1'b0;
            writePending <= 1'b0;
        end else if (execStrobe) begin
            readPending  <= isRead;
            writePending <= isWrite;
        end
    end

    assign mem.read      = memStrobe & readPending;
    assign mem.write     = memStrobe & writePending;
    assign mem.address   = addressReg;
    assign mem.writeData = storeDataReg;

    assign writeBackData = (dec.opcode == OP_LOAD) ? mem.readData : resultReg;

    // PC register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= ResetPc;
        end else if (pcStrobe) begin
            if (dec.opcode == OP_RETURN) begin
                pc <= mem.readData; // Popped return address
            end else if (execStrobe) begin
                pc <= nextPc; // Jumps end in EXECUTE, register not loaded yet
            end else begin
                pc <= nextPcReg;
            end
        end
    end

    noReadAndWrite : assert property (@(posedge clk) disable iff (reset)
        !(mem.read && mem.write));

endmodule

/* files.f */
common/tinkerPkg.sv
common/decodeIf.sv
common/dataPortIf.sv
control/coreControl.sv
execute/executeUnit.sv
logic/registerFile.sv
memory/unifiedMemory.sv
logic/tinkerCore.sv
verification/tinkerCoreTb.sv

/* logic/registerFile.sv */
`timescale 1ns/10ps

module registerFile
    import tinkerPkg::*;
#(
    parameter int MemBytes = DefaultMemBytes
) (
    input  logic  clk,
    input  logic  reset,
    decodeIf.regs dec,
    input  logic  regWrite,
    input  wordT  writeData,
    output wordT  rsValue,
    output wordT  rtValue,
    output wordT  rdValue,
    output wordT  stackPtr
);

    wordT registers [32]; // r0 is an ordinary register

    // Write port, stack starts at the top of memory
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
            registers[StackReg] <= wordT'(MemBytes);
        end else if (regWrite) begin
            registers[dec.rd] <= writeData;
        end
    end

    // ------------------------------------------------------------------------
    // Read ports, always valid
    // ------------------------------------------------------------------------
    assign rsValue  = registers[dec.rs];
    assign rtValue  = registers[dec.rt];
    assign rdValue  = registers[dec.rd]; // Store base and jump target
    assign stackPtr = registers[StackReg];

endmodule

/* logic/tinkerCore.sv */
`timescale 1ns/10ps

module tinkerCore
    import tinkerPkg::*;
#(
    parameter int   MemBytes = DefaultMemBytes,
    parameter wordT ResetPc  = DefaultResetPc
) (
    input  logic clk,
    input  logic reset,
    output logic hlt,
    input  logic hostWrite,     // Program load and result read
    input  wordT hostAddress,
    input  wordT hostWriteData,
    output wordT hostReadData
);

    instrT instruction;
    wordT  pc;
    wordT  rsValue;
    wordT  rtValue;
    wordT  rdValue;
    wordT  stackPtr;
    wordT  writeBackData;
    logic  execStrobe;
    logic  memStrobe;
    logic  pcStrobe;
    logic  regWrite;

    decodeIf   dec ();      // Latched instruction fields
    dataPortIf dataPort (); // Core data accesses

    // ------------------------------------------------------------------------
    // Core blocks
    // ------------------------------------------------------------------------
    coreControl u_control (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .dec         (dec.ctrl),
        .execStrobe  (execStrobe),
        .memStrobe   (memStrobe),
        .pcStrobe    (pcStrobe),
        .regWrite    (regWrite),
        .hlt         (hlt)
    );

    executeUnit #(.ResetPc(ResetPc)) u_execute (
        .clk           (clk),
        .reset         (reset),
        .dec           (dec.exec),
        .rsValue       (rsValue),
        .rtValue       (rtValue),
        .rdValue       (rdValue),
        .stackPtr      (stackPtr),
        .execStrobe    (execStrobe),
        .memStrobe     (memStrobe),
        .pcStrobe      (pcStrobe),
        .mem           (dataPort.exec),
        .pc            (pc),
        .writeBackData (writeBackData)
    );

    registerFile #(.MemBytes(MemBytes)) u_registers (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec.regs),
        .regWrite  (regWrite),
        .writeData (writeBackData),
        .rsValue   (rsValue),
        .rtValue   (rtValue),
        .rdValue   (rdValue),
        .stackPtr  (stackPtr)
    );

    unifiedMemory #(.MemBytes(MemBytes)) u_memory (
        .clk           (clk),
        .pc            (pc),
        .instruction   (instruction),
        .mem           (dataPort.mem),
        .hostWrite     (hostWrite),
        .hostAddress   (hostAddress),
        .hostWriteData (hostWriteData),
        .hostReadData  (hostReadData)
    );

endmodule

/* memory/unifiedMemory.sv */
`timescale 1ns/10ps

module unifiedMemory
    import tinkerPkg::*;
#(
    parameter int MemBytes = DefaultMemBytes // Power of two
) (
    input  logic  clk,
    input  wordT  pc,
    output instrT instruction,
    dataPortIf.mem mem,
    input  logic  hostWrite,
    input  wordT  hostAddress,
    input  wordT  hostWriteData,
    output wordT  hostReadData
);

    localparam int AddrBits = $clog2(MemBytes);
    localparam wordT LastWord = wordT'(MemBytes - 8); // Highest full-word start

    typedef logic [AddrBits-1:0] addrT; // Wrapped byte index

    logic [7:0] storage [MemBytes];

    // Little-endian read of count bytes, upper bytes zero
    function automatic wordT readLe(wordT base, int unsigned count);
        wordT value;
        value = '0;
        for (int k = 0; k < 8; k++) begin
            if (k < count) begin
                value[8*k +: 8] = storage[addrT'(base + wordT'(k))];
            end
        end
        return value;
    endfunction

    // ------------------------------------------------------------------------
    // Read ports, all combinational
    // ------------------------------------------------------------------------
    always_comb begin
        instruction  = instrT'(readLe(pc, 4)); // 4-byte fetch
        mem.readData = readLe(mem.address, 8);
        hostReadData = readLe(hostAddress, 8);
    end

    // Write ports, host last so it wins a collision
    always_ff @(posedge clk) begin
        if (mem.write) begin
            for (int k = 0; k < 8; k++) begin
                storage[addrT'(mem.address + wordT'(k))] <= mem.writeData[8*k +: 8];
            end
        end
        if (hostWrite) begin
            for (int k = 0; k < 8; k++) begin
                storage[addrT'(hostAddress + wordT'(k))] <= hostWriteData[8*k +: 8];
            end
        end
    end

    // Core data words stay inside the array
    noWrapAccess : assert property (@(posedge clk)
        (mem.read || mem.write) |-> (wordT'(addrT'(mem.address)) <= LastWord));

endmodule

/* verification/tinkerCoreTb.sv */
`timescale 1ns/10ps

module tinkerCoreTb
    import tinkerPkg::*;
();

    localparam wordT ProgBase  = DefaultResetPc;
    localparam wordT StackWord = wordT'(DefaultMemBytes - 8); // CALL pushes here

    logic clk;
    logic reset;
    logic hlt;
    logic hostWrite;
    wordT hostAddress;
    wordT hostWriteData;
    wordT hostReadData;

    instrT image[$];      // Program under construction
    wordT  loadAddr[$];   // Host writes issued during reset
    wordT  loadData[$];
    logic [31:0] lfsr;
    int testErrors;
    int passCount;
    int failCount;
    int cycleCount = 0;
    int cycleLimit = 0;   // Grows by each test's budget

    tinkerCore u_dut (
        .clk           (clk),
        .reset         (reset),
        .hlt           (hlt),
        .hostWrite     (hostWrite),
        .hostAddress   (hostAddress),
        .hostWriteData (hostWriteData),
        .hostReadData  (hostReadData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run reached its limit of %0d cycles", cycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Galois LFSR random source stepped once per bit
    // ------------------------------------------------------------------------
    function automatic logic randomBit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
        end
        return out;
    endfunction

    function automatic wordT randomBits(int count);
        wordT value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[62:0], randomBit()};
        end
        return value;
    endfunction

    // ------------------------------------------------------------------------
    // Program assembly
    // ------------------------------------------------------------------------
    function automatic void emit(logic [4:0] op, int rd, int rs, int rt, int lit);
        image.push_back({op, regIndexT'(rd), regIndexT'(rs), regIndexT'(rt), literalT'(lit)});
    endfunction

    function automatic wordT here();
        return ProgBase + wordT'(4 * image.size()); // Address of next instruction
    endfunction

    function automatic void store(int base, int src, int offset);
        emit(OP_STORE, base, src, 0, offset); // mem[r[base] + offset] = r[src]
    endfunction

    // r10 holds the 16-byte aligned result base below 64K
    function automatic void setBase(wordT addr);
        emit(OP_LI, 10, 0, 0, int'(addr >> 4));
        emit(OP_SHLI, 10, 0, 0, 4);
    endfunction

    function automatic void marker(int slot, int value);
        emit(OP_LI, 7, 0, 0, value);
        store(10, 7, 8 * slot);
    endfunction

    // Full 64-bit constant as 4 bits then five 12-bit chunks
    function automatic void loadValue(int rd, wordT value);
        emit(OP_LI, rd, 0, 0, int'(value[63:60]));
        for (int c = 4; c >= 0; c--) begin
            emit(OP_SHLI, rd, 0, 0, 12);
            emit(OP_LI, rd, 0, 0, int'(value[12*c +: 12]));
        end
    endfunction

    // Code address load with low 12 bits patched once the label is known
    function automatic int addressSlot(int rd);
        emit(OP_XOR, rd, rd, rd, 0); // Clear first since LI keeps the upper bits
        emit(OP_LI, rd, 0, 0, int'(ProgBase >> 12));
        emit(OP_SHLI, rd, 0, 0, 12);
        emit(OP_LI, rd, 0, 0, 0);
        return image.size() - 1;
    endfunction

    function automatic void patchLabel(int slot);
        wordT addr;
        addr = here();
        image[slot] = {image[slot][31:12], addr[11:0]};
    endfunction

    function automatic wordT fillWord(wordT addr);
        return (addr * 64'h9E37_79B9_7F4A_7C15) ^ 64'h0F0F_F0F0_5AA5_A55A;
    endfunction

    function automatic void preload(wordT addr, wordT data);
        loadAddr.push_back(addr);
        loadData.push_back(data);
    endfunction

    // ------------------------------------------------------------------------
    // Run control and checking
    // ------------------------------------------------------------------------
    function automatic void checkValue(string name, wordT actual, wordT expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            testErrors++;
        end
    endfunction

    task automatic checkWord(string name, wordT addr, wordT expected);
        @(posedge clk);
        hostAddress <= addr;
        @(negedge clk); // Combinational read settled
        checkValue($sformatf("hostReadData %s @%h", name, addr), hostReadData, expected);
    endtask

    task automatic startTest();
        image.delete();
        loadAddr.delete();
        loadData.delete();
        testErrors = 0;
    endtask

    task automatic finishTest(string name);
        if (testErrors == 0) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s, %0d mismatches", name, testErrors);
        end
    endtask

    // Load during reset then release and wait for halt
    task automatic runProgram();
        int resetCycles;
        wordT pair;
        for (int i = 0; i < image.size(); i += 2) begin
            pair = {32'h0, image[i]}; // Two instructions per little-endian word
            if (i + 1 < image.size()) begin
                pair[63:32] = image[i + 1];
            end
            preload(ProgBase + wordT'(4 * i), pair);
        end
        resetCycles = (loadAddr.size() > 16) ? loadAddr.size() : 16;
        cycleLimit += 5 * image.size() + resetCycles + 50;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < resetCycles; i++) begin
            hostWrite <= (i < loadAddr.size());
            if (i < loadAddr.size()) begin
                hostAddress   <= loadAddr[i];
                hostWriteData <= loadData[i];
            end
            @(negedge clk);
            checkValue("hlt during reset", wordT'(hlt), '0);
            @(posedge clk);
        end
        hostWrite <= 1'b0;
        reset     <= 1'b0;
        @(negedge clk);
        while (hlt !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic aluTest();
        wordT a;
        wordT b;
        wordT sh;
        wordT expected[9];
        opcodeT ops[9];
        string names[9];
        startTest();
        a  = randomBits(64);
        b  = randomBits(64);
        sh = randomBits(6);
        ops = '{OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHR, OP_SHL};
        names = '{"ADD", "SUB", "MUL", "AND", "OR", "XOR", "NOT", "SHR", "SHL"};
        expected = '{a + b, a - b, a * b, a & b, a | b, a ^ b, ~a, a >> sh, a << sh};
        loadValue(1, a);
        loadValue(2, b);
        emit(OP_LI, 3, 0, 0, int'(sh));
        setBase(64'h4000);
        for (int i = 0; i < 9; i++) begin
            emit(ops[i], 4, 1, (i >= 7) ? 3 : 2, 0); // Shifts take r3
            store(10, 4, 8 * i);
        end
        emit(OP_HLT, 0, 0, 0, 0);
        runProgram();
        for (int i = 0; i < 9; i++) begin
            checkWord(names[i], 64'h4000 + wordT'(8 * i), expected[i]);
        end
        finishTest("register ALU operations");
    endtask

    task automatic immediateTest();
        wordT a;
        wordT expected[8];
        int l1;
        int l2;
        int l3;
        int s1;
        int s2;
        startTest();
        a  = randomBits(64);
        l1 = int'(randomBits(12));
        l2 = int'(randomBits(12));
        s1 = int'(randomBits(6));
        s2 = int'(randomBits(6));
        l3 = int'(randomBits(12));
        expected[0] = a + wordT'(l1);
        expected[1] = expected[0] - wordT'(l2);
        expected[2] = expected[1] >> s1;
        expected[3] = expected[2] << s2;
        expected[4] = {expected[3][63:12], literalT'(l3)}; // Upper bits kept
        expected[5] = expected[4];  // Move
        expected[6] = expected[4];  // Untouched by FADD
        expected[7] = 64'h5A;
        loadValue(1, a);
        setBase(64'h4080);
        emit(OP_ADDI, 1, 9, 0, l1); // rs field must be ignored
        store(10, 1, 0);
        emit(OP_SUBI, 1, 9, 0, l2);
        store(10, 1, 8);
        emit(OP_SHRI, 1, 9, 0, s1);
        store(10, 1, 16);
        emit(OP_SHLI, 1, 9, 0, s2);
        store(10, 1, 24);
        emit(OP_LI, 1, 9, 0, l3);
        store(10, 1, 32);
        emit(OP_MOV, 2, 1, 0, 0);
        store(10, 2, 40);
        emit(5'h14, 2, 1, 1, 0);    // Dropped FADD
        store(10, 2, 48);
        marker(7, 12'h5A);
        emit(OP_HLT, 0, 0, 0, 0);
        runProgram();
        for (int i = 0; i < 8; i++) begin
            checkWord($sformatf("immediate step %0d", i), 64'h4080 + wordT'(8 * i),
                      expected[i]);
        end
        finishTest("immediate forms");
    endtask

    task automatic loadStoreTest();
        wordT d[4];
        startTest();
        for (int i = 0; i < 4; i++) begin
            d[i] = randomBits(64);
            preload(64'h4100 + wordT'(8 * i), d[i]);
        end
        for (int i = 4; i < 7; i++) begin
            preload(64'h4100 + wordT'(8 * i), fillWord(64'h4100 + wordT'(8 * i)));
        end
        setBase(64'h4100);
        emit(OP_LOAD, 1, 10, 0, 0);
        emit(OP_LOAD, 2, 10, 0, 8);
        emit(OP_LOAD, 3, 10, 0, 16);
        emit(OP_ADD, 4, 1, 2, 0);
        store(10, 4, 32);
        emit(OP_ADD, 5, 4, 3, 0);
        store(10, 5, 40);
        emit(OP_HLT, 0, 0, 0, 0);
        runProgram();
        for (int i = 0; i < 4; i++) begin
            checkWord("preloaded word", 64'h4100 + wordT'(8 * i), d[i]);
        end
        checkWord("two-word sum", 64'h4120, d[0] + d[1]);
        checkWord("three-word sum", 64'h4128, d[0] + d[1] + d[2]);
        checkWord("untouched word", 64'h4130, fillWord(64'h4130));
        finishTest("load and store");
    endtask

    task automatic branchTest();
        wordT expected[11];
        int target;
        int bad;
        startTest();
        for (int i = 0; i < 11; i++) begin
            expected[i] = fillWord(64'h4200 + wordT'(8 * i));
            preload(64'h4200 + wordT'(8 * i), expected[i]);
        end
        setBase(64'h4200);
        emit(OP_LI, 1, 0, 0, 1);
        emit(OP_LI, 3, 0, 0, 5);
        emit(OP_SUBI, 4, 0, 0, 3);    // r4 = -3
        emit(OP_LI, 9, 0, 0, 12);     // JMPA offset
        bad = addressSlot(8);         // Wrongly taken branches land here
        target = addressSlot(6);
        emit(OP_BRNZ, 6, 1, 0, 0);    // Taken
        marker(0, 12'hBAD);
        patchLabel(target);
        marker(1, 1);
        emit(OP_BRNZ, 8, 2, 0, 0);    // r2 zero
        marker(2, 2);
        target = addressSlot(6);
        emit(OP_BRGT, 6, 3, 4, 0);    // 5 > -3 signed
        marker(3, 12'hBAD);
        patchLabel(target);
        marker(4, 3);
        emit(OP_BRGT, 8, 4, 3, 0);    // Would be taken if unsigned
        marker(5, 4);
        target = addressSlot(6);
        emit(OP_JMPR, 6, 0, 0, 0);
        marker(6, 12'hBAD);
        patchLabel(target);
        emit(OP_JMPAI, 0, 0, 0, 12);  // Skips one marker pair
        marker(7, 12'hBAD);
        emit(OP_JMPA, 9, 0, 0, 0);
        marker(8, 12'hBAD);
        marker(9, 5);
        emit(OP_HLT, 0, 0, 0, 0);
        patchLabel(bad);
        marker(10, 12'hBAD);
        emit(OP_HLT, 0, 0, 0, 0);
        runProgram();
        expected[1] = 64'd1;
        expected[2] = 64'd2;
        expected[4] = 64'd3;
        expected[5] = 64'd4;
        expected[9] = 64'd5;
        for (int i = 0; i < 11; i++) begin
            checkWord($sformatf("branch marker %0d", i), 64'h4200 + wordT'(8 * i),
                      expected[i]);
        end
        finishTest("jumps and branches");
    endtask

    task automatic callReturnTest();
        wordT callAddr;
        int target;
        startTest();
        preload(64'h4300, fillWord(64'h4300));
        preload(64'h4308, fillWord(64'h4308));
        preload(StackWord, fillWord(StackWord));
        setBase(64'h4300);
        target = addressSlot(6);
        callAddr = here();
        emit(OP_CALL, 6, 0, 0, 0);
        marker(1, 12'h22);            // Runs after return
        emit(OP_HLT, 0, 0, 0, 0);
        patchLabel(target);
        marker(0, 12'h11);            // Subroutine body
        emit(OP_RETURN, 0, 0, 0, 0);
        runProgram();
        checkWord("return address", StackWord, callAddr + 64'd4);
        checkWord("subroutine marker", 64'h4300, 64'h11);
        checkWord("resume marker", 64'h4308, 64'h22);
        finishTest("CALL and RETURN");
    endtask

    task automatic haltTest();
        startTest();
        preload(64'h4400, fillWord(64'h4400));
        preload(64'h4408, fillWord(64'h4408));
        setBase(64'h4400);
        marker(0, 12'h66);
        emit(OP_HLT, 0, 0, 0, 0);
        marker(1, 12'h77);            // Never reached
        emit(OP_HLT, 0, 0, 0, 0);
        runProgram();                 // hlt low through reset
        @(posedge clk);
        hostAddress <= 64'h4400;
        repeat (50) begin
            @(negedge clk);
            checkValue("hlt while halted", wordT'(hlt), 64'd1);
            checkValue("hostReadData halt marker", hostReadData, 64'h66);
        end
        checkWord("post-halt marker", 64'h4408, fillWord(64'h4408));
        finishTest("halt");
    endtask

    // ------------------------------------------------------------------------
    // Sequence and report
    // ------------------------------------------------------------------------
    initial begin
        reset         = 1'b1;
        hostWrite     = 1'b0;
        hostAddress   = '0;
        hostWriteData = '0;
        lfsr          = 32'd87;
        passCount     = 0;
        failCount     = 0;
        testErrors    = 0;
        aluTest();
        immediateTest();
        loadStoreTest();
        branchTest();
        callReturnTest();
        haltTest();
        $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
